// ==== design/fp16_macros.svh ====
`ifndef FP16_MACROS_SVH
`define FP16_MACROS_SVH

// Half-precision field layout
`define HALF_WIDTH 16   // Sign, exponent, mantissa
`define EXP_WIDTH 5
`define MAN_WIDTH 10    // Stored fraction only
`define SIG_WIDTH 11    // Hidden bit plus fraction

// Carry bit, significand, then five guard positions
`define SUM_WIDTH 17

// Loop and memory
`define ACCUM_COUNT 8   // Values summed per start
`define ADDR_WIDTH 3

// Adder cycles from operand sample to result
`define ADD_LATENCY 4

`endif

// ==== design/fp16Pkg.sv ====
`include "fp16_macros.svh"

package fp16Pkg;

	// Raw exponent field, bias 15
	typedef logic [`EXP_WIDTH-1:0] expField;

	// Hidden bit on top of the stored mantissa
	typedef logic [`SIG_WIDTH-1:0] significand;

	// Adder datapath sum
	// Bit 16 carry, bit 15 hidden position, low five bits below the significand LSB
	typedef logic [`SUM_WIDTH-1:0] extSum;

	// Word index into the operand memory
	typedef logic [`ADDR_WIDTH-1:0] accumAddr;

	// IEEE half value
	typedef struct packed {
		logic sign;
		expField exponent;
		logic [`MAN_WIDTH-1:0] mantissa;
	} halfFloat;

endpackage

// ==== design/fpAlign.sv ====
`include "fp16_macros.svh"

module fpAlign (
	input  fp16Pkg::halfFloat   opA,
	input  fp16Pkg::halfFloat   opB,
	output fp16Pkg::expField    commonExp,
	output fp16Pkg::significand largerSig,
	output fp16Pkg::significand smallerSig,
	output logic                signLarger,
	output logic                signSmaller,
	output logic                subtract
);
	import fp16Pkg::*;

	logic aIsLarger;            // Magnitude compare result
	halfFloat larger;
	halfFloat smaller;
	expField largerExp;         // Effective exponents
	expField smallerExp;
	expField expDiff;
	significand smallerFull;    // Smaller significand before the shift

	// Exponent and mantissa together order the magnitudes, sign ignored
	assign aIsLarger = {opA.exponent, opA.mantissa} >= {opB.exponent, opB.mantissa}; // Tie keeps A
	assign larger = aIsLarger ? opA : opB;
	assign smaller = aIsLarger ? opB : opA;

	// Zero exponent field reads as exponent one with no hidden bit
	assign largerExp = (larger.exponent == '0) ? expField'(1) : larger.exponent;
	assign smallerExp = (smaller.exponent == '0) ? expField'(1) : smaller.exponent;

	assign largerSig = {|larger.exponent, larger.mantissa};
	assign smallerFull = {|smaller.exponent, smaller.mantissa};

	// Never negative, larger exponent always wins the compare above
	assign expDiff = largerExp - smallerExp;

	// Truncating right shift, bits falling off are lost
	always_comb begin
		if (expDiff >= expField'(`SIG_WIDTH + 1)) begin
			smallerSig = '0;    // Far out of range
		end else begin
			smallerSig = smallerFull >> expDiff;
		end
	end

	assign commonExp = largerExp;       // Result starts at the larger exponent
	assign signLarger = larger.sign;
	assign signSmaller = smaller.sign;
	assign subtract = opA.sign ^ opB.sign;   // Effective subtract on mixed signs

endmodule

// ==== design/fpSignificandAdd.sv ====
`include "fp16_macros.svh"

module fpSignificandAdd (
	input  fp16Pkg::significand largerSig,
	input  fp16Pkg::significand smallerSig,
	input  logic                subtract,
	input  logic                signLarger,
	output fp16Pkg::extSum      rawSum,
	output logic                resultSign
);
	import fp16Pkg::*;

	localparam int GuardBits = `SUM_WIDTH - `SIG_WIDTH - 1;

	extSum largerExt;     // Carry slot on top, guard slots below
	extSum smallerExt;

	assign largerExt = {1'b0, largerSig, {GuardBits{1'b0}}};
	assign smallerExt = {1'b0, smallerSig, {GuardBits{1'b0}}};

	// Larger magnitude on the left, so a subtract never goes negative
	always_comb begin
		if (subtract) begin
			rawSum = largerExt - smallerExt;
		end else begin
			rawSum = largerExt + smallerExt;    // Carry lands in the top bit
		end
	end

	// Magnitude winner sets the sign
	// Exact cancellation is fixed up after normalize
	assign resultSign = signLarger;

endmodule

// ==== design/fpNormalizeRound.sv ====
`include "fp16_macros.svh"

module fpNormalizeRound (
	input  fp16Pkg::extSum    rawSum,
	input  fp16Pkg::expField  commonExp,
	input  logic              resultSign,
	input  logic              signSmaller,
	output fp16Pkg::halfFloat rounded
);
	import fp16Pkg::*;

	localparam int LzWidth = $clog2(`SUM_WIDTH + 1);
	localparam int GuardPos = `SUM_WIDTH - `SIG_WIDTH - 1;    // Bit just below the mantissa LSB

	logic [LzWidth-1:0] leadZeros;    // Zeros above the leading one, carry bit included
	extSum normSum;                   // Leading one moved to the carry position
	logic [`EXP_WIDTH:0] normExp;     // One spare bit
	logic [`MAN_WIDTH-1:0] normMan;
	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;
	logic zeroSum;
	logic [`MAN_WIDTH:0] manRounded;  // Top bit is the rounding carry
	expField finalExp;

	// Leading-one search, highest set bit wins
	always_comb begin
		leadZeros = LzWidth'(`SUM_WIDTH);    // All clear
		for (int i = 0; i < `SUM_WIDTH; i++) begin
			if (rawSum[i]) begin
				leadZeros = LzWidth'(`SUM_WIDTH - 1 - i);
			end
		end
	end

	assign zeroSum = (rawSum == '0);

	// Carry set means no shift and exponent plus one
	// Otherwise a left shift with the exponent falling one per extra position
	assign normSum = rawSum << leadZeros;
	assign normExp = {1'b0, commonExp} + 1'b1 - leadZeros;

	assign normMan = normSum[`SUM_WIDTH-2 -: `MAN_WIDTH];    // Bits below the leading one
	assign guardBit = normSum[GuardPos];
	assign roundBit = normSum[GuardPos-1];
	assign stickyBit = |normSum[GuardPos-2:0];

	// Nearest even, exact halfway goes to an even mantissa
	assign roundUp = guardBit & (roundBit | stickyBit | normMan[0]);
	assign manRounded = {1'b0, normMan} + roundUp;

	// Mantissa wrap carries into the exponent
	always_comb begin
		if (zeroSum) begin
			finalExp = '0;
		end else begin
			finalExp = normExp[`EXP_WIDTH-1:0] + manRounded[`MAN_WIDTH];
		end
	end

	// Cancellation gives +0, two negatives give -0
	assign rounded.sign = zeroSum ? (resultSign & signSmaller) : resultSign;
	assign rounded.exponent = finalExp;
	assign rounded.mantissa = manRounded[`MAN_WIDTH-1:0];    // Zero after a wrap

endmodule

// ==== design/fp16Adder.sv ====
module fp16Adder (
	input  logic              ap_clk,
	input  fp16Pkg::halfFloat addA,
	input  fp16Pkg::halfFloat addB,
	output fp16Pkg::halfFloat addResult
);
	import fp16Pkg::*;

	// Stage 1 operands
	halfFloat opAReg;
	halfFloat opBReg;

	// Align outputs and stage 2
	expField alignExp, alignExpReg;
	significand largerSig, largerSigReg;
	significand smallerSig, smallerSigReg;
	logic signLarger, signLargerReg;
	logic signSmaller, signSmallerReg;
	logic subtract, subtractReg;

	// Sum and stage 3
	extSum rawSum, rawSumReg;
	logic resultSign, resultSignReg;
	expField sumExpReg;           // Common exponent carried along
	logic sumSignSmallerReg;      // Needed for the zero sign

	halfFloat rounded;            // Into the stage 4 output register

	fpAlign fpAlignInst (
		.opA        (opAReg),
		.opB        (opBReg),
		.commonExp  (alignExp),
		.largerSig  (largerSig),
		.smallerSig (smallerSig),
		.signLarger (signLarger),
		.signSmaller(signSmaller),
		.subtract   (subtract)
	);

	fpSignificandAdd fpSignificandAddInst (
		.largerSig (largerSigReg),
		.smallerSig(smallerSigReg),
		.subtract  (subtractReg),
		.signLarger(signLargerReg),
		.rawSum    (rawSum),
		.resultSign(resultSign)
	);

	fpNormalizeRound fpNormalizeRoundInst (
		.rawSum     (rawSumReg),
		.commonExp  (sumExpReg),
		.resultSign (resultSignReg),
		.signSmaller(sumSignSmallerReg),
		.rounded    (rounded)
	);

	// New operands every cycle
	always_ff @(posedge ap_clk) begin
		opAReg <= addA;
		opBReg <= addB;
		alignExpReg <= alignExp;            // Stage 2
		largerSigReg <= largerSig;
		smallerSigReg <= smallerSig;
		signLargerReg <= signLarger;
		signSmallerReg <= signSmaller;
		subtractReg <= subtract;
		rawSumReg <= rawSum;                // Stage 3
		resultSignReg <= resultSign;
		sumExpReg <= alignExpReg;
		sumSignSmallerReg <= signSmallerReg;
		addResult <= rounded;               // Stage 4
	end

endmodule

// ==== design/accumControl.sv ====
`include "fp16_macros.svh"

module accumControl (
	input  logic              ap_clk,
	input  logic              ap_rst,
	input  logic              ap_start,
	input  logic              ap_continue,
	output logic              ap_done,
	output logic              ap_idle,
	output logic              ap_ready,
	output fp16Pkg::accumAddr accumAddress,
	output logic              accumReadEnable,
	input  fp16Pkg::halfFloat accumData,
	output fp16Pkg::halfFloat accumSum,
	output logic              accumSumValid,
	output fp16Pkg::halfFloat addA,
	output fp16Pkg::halfFloat addB,
	input  fp16Pkg::halfFloat addResult
);
	import fp16Pkg::*;

	localparam int IndexWidth = $clog2(`ACCUM_COUNT + 1);    // Must reach the count itself
	localparam int WaitWidth = $clog2(`ADD_LATENCY + 1);
	localparam halfFloat PosZero = halfFloat'(`HALF_WIDTH'(0));

	typedef enum logic [1:0] {
		StIdle,
		StRead,       // Strobe a read or finish
		StCapture,    // Memory word arrives
		StWait        // Adder latency
	} ctrlState;

	ctrlState state, stateNext;
	logic doneHeld;               // Done waiting for continue
	logic startAccept;
	logic finishRun;
	logic sumLoad;
	logic [IndexWidth-1:0] index;
	logic [WaitWidth-1:0] waitCount;
	halfFloat runningSum;
	halfFloat capturedWord;
	halfFloat heldSum;            // Last result between runs

	assign startAccept = (state == StIdle) && ap_start && !doneHeld;
	assign finishRun = (state == StRead) && (index == IndexWidth'(`ACCUM_COUNT));
	assign sumLoad = (state == StWait) && (waitCount == '0);

	always_comb begin
		stateNext = state;
		case (state)
			StIdle: if (startAccept) stateNext = StRead;
			StRead: stateNext = finishRun ? StIdle : StCapture;
			StCapture: stateNext = StWait;
			StWait: if (waitCount == '0) stateNext = StRead;
			default: stateNext = StIdle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= StIdle;
			doneHeld <= 1'b0;
			index <= '0;
			waitCount <= '0;
			heldSum <= PosZero;
		end else begin
			state <= stateNext;
			if (ap_continue) doneHeld <= 1'b0;    // Continue wins over a new finish
			else if (finishRun) doneHeld <= 1'b1;
			if (startAccept) index <= '0;
			else if (sumLoad) index <= index + 1'b1;
			if (state == StCapture) waitCount <= WaitWidth'(`ADD_LATENCY - 1);
			else if (state == StWait) waitCount <= waitCount - 1'b1;
			if (finishRun) heldSum <= runningSum;
		end
	end

	// Sum and word registers
	always_ff @(posedge ap_clk) begin
		if (startAccept) runningSum <= PosZero;
		else if (sumLoad) runningSum <= addResult;    // Adder output settled by now
		if (state == StCapture) capturedWord <= accumData;
	end

	// Adder samples at the end of capture, so the memory word bypasses the capture register
	assign addB = (state == StCapture) ? accumData : capturedWord;
	assign addA = runningSum;

	assign accumAddress = index[`ADDR_WIDTH-1:0];
	assign accumReadEnable = (state == StRead) && !finishRun;

	// Finish cycle shows the sum before it lands in the hold register
	assign accumSum = finishRun ? runningSum : heldSum;
	assign accumSumValid = finishRun;
	assign ap_done = doneHeld | finishRun;
	assign ap_ready = finishRun;
	assign ap_idle = (state == StIdle) && !ap_start;

	// A held done blocks memory traffic in the next cycle too
	assert property (@(posedge ap_clk) disable iff (ap_rst)
		(ap_done && !ap_continue) |=> !accumReadEnable);

	// Ready lasts one cycle and done stays up behind it
	assert property (@(posedge ap_clk) disable iff (ap_rst)
		(ap_ready && !ap_continue) |=> (ap_done && !ap_ready));

	assert property (@(posedge ap_clk) disable iff (ap_rst)
		accumReadEnable |-> (index < IndexWidth'(`ACCUM_COUNT)));

endmodule

// ==== design/fp16AccumTop.sv ====
module fp16AccumTop (
	input  logic              ap_clk,
	input  logic              ap_rst,
	input  logic              ap_start,
	input  logic              ap_continue,
	output logic              ap_done,
	output logic              ap_idle,
	output logic              ap_ready,
	output fp16Pkg::accumAddr accumAddress,
	output logic              accumReadEnable,
	input  fp16Pkg::halfFloat accumData,
	output fp16Pkg::halfFloat accumSum,
	output logic              accumSumValid
);
	import fp16Pkg::*;

	halfFloat addA;         // Running sum into the adder
	halfFloat addB;         // Memory word
	halfFloat addResult;

	accumControl accumControlInst (
		.ap_clk         (ap_clk),
		.ap_rst         (ap_rst),
		.ap_start       (ap_start),
		.ap_continue    (ap_continue),
		.ap_done        (ap_done),
		.ap_idle        (ap_idle),
		.ap_ready       (ap_ready),
		.accumAddress   (accumAddress),
		.accumReadEnable(accumReadEnable),
		.accumData      (accumData),
		.accumSum       (accumSum),
		.accumSumValid  (accumSumValid),
		.addA           (addA),
		.addB           (addB),
		.addResult      (addResult)
	);

	// Four cycles, no valid, the controller counts instead
	fp16Adder fp16AdderInst (
		.ap_clk   (ap_clk),
		.addA     (addA),
		.addB     (addB),
		.addResult(addResult)
	);

endmodule

// ==== verif/fp16AccumTb.sv ====
`include "fp16_macros.svh"

module fp16AccumTb;
	timeunit 1ns;
	timeprecision 1ps;
	import fp16Pkg::*;

	localparam int ClockPeriod = 4;
	localparam int RandomRuns = 10;
	localparam int RunCount = RandomRuns + 3;    // Random fills plus three fixed fills
	localparam int RunCycles = 1 + `ACCUM_COUNT * (`ADD_LATENCY + 2);    // Accept edge to done
	localparam int HoldCycles = 6;               // Done held with start still high

	logic ap_clk;
	logic ap_rst;
	logic ap_start;
	logic ap_continue;
	logic ap_done;
	logic ap_idle;
	logic ap_ready;
	accumAddr accumAddress;
	logic accumReadEnable;
	halfFloat accumData;
	halfFloat accumSum;
	logic accumSumValid;

	halfFloat mem [`ACCUM_COUNT];    // Memory model contents
	halfFloat expectedSum;
	accumAddr readQueue[$];          // Addresses seen this run
	string currentTest;
	int seed = 32'hacdd;
	int cycleCount = 0;
	int acceptCycle;
	int strobeCycle;
	logic strobeSeen;
	int errorCount = 0;
	int testCount = 0;
	int testsPassed = 0;

	fp16AccumTop fp16AccumTop_inst (
		.ap_clk         (ap_clk),
		.ap_rst         (ap_rst),
		.ap_start       (ap_start),
		.ap_continue    (ap_continue),
		.ap_done        (ap_done),
		.ap_idle        (ap_idle),
		.ap_ready       (ap_ready),
		.accumAddress   (accumAddress),
		.accumReadEnable(accumReadEnable),
		.accumData      (accumData),
		.accumSum       (accumSum),
		.accumSumValid  (accumSumValid)
	);

	initial begin
		ap_clk = 1'b0;
		forever #(ClockPeriod / 2) ap_clk = ~ap_clk;
	end

	always @(posedge ap_clk) cycleCount <= cycleCount + 1;

	// Memory answers one cycle after the strobe
	always @(posedge ap_clk) begin
		if (accumReadEnable) accumData <= mem[accumAddress];
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errorCount++;
			$display("error %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Half add on plain integers with the larger magnitude first
	function automatic halfFloat fp16AddModel(halfFloat a, halfFloat b);
		halfFloat bigOp;
		halfFloat smallOp;
		halfFloat res;
		int bigExp;
		int smallExp;
		int bigSig;
		int smallSig;
		int shift;
		int sum;
		int msb;
		int norm;
		int man;
		int exp;
		int guard;
		int rest;
		if ({a.exponent, a.mantissa} >= {b.exponent, b.mantissa}) begin
			bigOp = a;
			smallOp = b;
		end else begin
			bigOp = b;
			smallOp = a;
		end
		bigExp = (bigOp.exponent == 0) ? 1 : bigOp.exponent;        // Field zero counts as one
		smallExp = (smallOp.exponent == 0) ? 1 : smallOp.exponent;
		bigSig = (bigOp.exponent == 0) ? bigOp.mantissa : bigOp.mantissa + 1024;
		smallSig = (smallOp.exponent == 0) ? smallOp.mantissa : smallOp.mantissa + 1024;
		shift = bigExp - smallExp;
		smallSig = (shift >= 12) ? 0 : (smallSig >> shift);     // Truncating align
		if (bigOp.sign != smallOp.sign) sum = bigSig * 32 - smallSig * 32;
		else sum = bigSig * 32 + smallSig * 32;
		res = '0;
		if (sum == 0) begin
			res.sign = bigOp.sign & smallOp.sign;    // Only two negatives keep -0
			return res;
		end
		msb = 16;
		while (((sum >> msb) & 1) == 0) msb--;
		norm = sum << (16 - msb);    // Leading one on bit 16
		exp = bigExp + msb - 15;
		man = (norm >> 6) & 1023;
		guard = (norm >> 5) & 1;
		rest = norm & 31;            // Round and sticky together
		if (guard == 1 && (rest != 0 || (man & 1) == 1)) man++;
		if (man == 1024) begin
			man = 0;
			exp++;
		end
		res.sign = bigOp.sign;
		res.exponent = expField'(exp);
		res.mantissa = man[`MAN_WIDTH-1:0];
		return res;
	endfunction

	function automatic halfFloat accumulateModel();
		halfFloat sum;
		int i;
		sum = '0;    // Run starts from +0
		for (i = 0; i < `ACCUM_COUNT; i++) sum = fp16AddModel(sum, mem[i]);
		return sum;
	endfunction

	// Read monitor and result compare
	always @(negedge ap_clk) begin
		if (accumReadEnable) readQueue.push_back(accumAddress);
		if (accumSumValid) begin
			checkValue({currentTest, " sum"}, expectedSum, accumSum);
			checkValue({currentTest, " ready"}, 1, ap_ready);
			checkValue({currentTest, " done"}, 1, ap_done);
			strobeCycle = cycleCount;
			strobeSeen = 1'b1;
		end
	end

	task automatic checkIdleOutputs(input string name);
		checkValue({name, " idle"}, 1, ap_idle);
		checkValue({name, " done"}, 0, ap_done);
		checkValue({name, " ready"}, 0, ap_ready);
		checkValue({name, " valid"}, 0, accumSumValid);
		checkValue({name, " read"}, 0, accumReadEnable);
	endtask

	task automatic fillRandom();
		int r;
		int i;
		for (i = 0; i < `ACCUM_COUNT; i++) begin
			r = $random(seed);
			mem[i].sign = r[15];
			mem[i].exponent = expField'(8 + ($unsigned(r) >> 16) % 13);    // 8 to 20
			mem[i].mantissa = r[`MAN_WIDTH-1:0];
		end
	endtask

	task automatic loadFill(input logic [127:0] words);
		int i;
		for (i = 0; i < `ACCUM_COUNT; i++) begin
			mem[i] = words[127 - 16 * i -: 16];    // First word on top
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	task automatic runAccum(input string name);
		int errorsBefore;
		int waited;
		int i;
		errorsBefore = errorCount;
		currentTest = name;
		expectedSum = accumulateModel();
		readQueue.delete();
		strobeSeen = 1'b0;
		@(posedge ap_clk);
		ap_start <= 1'b1;
		@(negedge ap_clk);
		acceptCycle = cycleCount + 1;    // Next edge takes the start
		waited = 0;
		while (!strobeSeen && waited < 2 * RunCycles) begin
			@(negedge ap_clk);
			waited++;
		end
		if (!strobeSeen) begin
			errorCount++;
			$display("%s: no result strobe after %0d cycles", name, waited);
		end else begin
			// Counted up to the edge that samples the strobe
			checkValue({name, " latency"}, RunCycles, strobeCycle + 1 - acceptCycle);
		end
		repeat (HoldCycles) begin
			@(negedge ap_clk);
			checkValue({name, " done held"}, 1, ap_done);
			checkValue({name, " ready pulse"}, 0, ap_ready);
		end
		checkValue({name, " read count"}, `ACCUM_COUNT, readQueue.size());
		for (i = 0; i < readQueue.size(); i++) begin
			checkValue({name, " read address"}, i, readQueue[i]);
		end
		@(posedge ap_clk);
		ap_start <= 1'b0;
		ap_continue <= 1'b1;
		@(posedge ap_clk);
		ap_continue <= 1'b0;
		@(negedge ap_clk);
		checkValue({name, " done cleared"}, 0, ap_done);
		finishTest(name, errorsBefore);
	endtask

	// Generous bound per run plus reset
	initial begin
		#(ClockPeriod * 100 * (RunCount + 1));
		$display("Watchdog timeout, the runs did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int run;
		int errorsBefore;
		ap_rst = 1'b1;
		ap_start = 1'b0;
		ap_continue = 1'b0;
		accumData = '0;
		errorsBefore = errorCount;
		@(posedge ap_clk);
		@(negedge ap_clk);
		checkIdleOutputs("reset");
		@(posedge ap_clk);
		ap_rst <= 1'b0;    // Two edges with reset high
		repeat (2) begin
			@(negedge ap_clk);
			checkIdleOutputs("after reset");
		end
		finishTest("reset", errorsBefore);
		for (run = 0; run < RandomRuns; run++) begin
			fillRandom();
			runAccum($sformatf("random%0d", run));
		end
		loadFill(128'h4a00_ca00_3c00_bc00_5123_d123_2abc_aabc);
		runAccum("cancel pairs");
		checkValue("cancel pairs plus zero", 16'h0000, accumSum);
		loadFill(128'hb800_c200_bc00_cd55_c3ff_a5a5_c8c8_b123);
		runAccum("all negative");
		checkValue("all negative sign", 1, accumSum.sign);
		// Carries leave exact halfway cases with even and odd mantissas
		loadFill(128'h3c01_3c00_4001_4403_4801_4c05_5001_5403);
		runAccum("round ties");
		checkValue("round ties final", 16'h5802, accumSum);
		$display("%0d of %0d tests passed, %0d errors", testsPassed, testCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+design
design/fp16Pkg.sv
design/fpAlign.sv
design/fpSignificandAdd.sv
design/fpNormalizeRound.sv
design/fp16Adder.sv
design/accumControl.sv
design/fp16AccumTop.sv
verif/fp16AccumTb.sv
